/* project.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/id_stage.sv
verification/id_stage_assertions.sv
verification/tb_id_stage.sv

/* run.sh */
#!/bin/sh
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_stage \
    -Mdir obj_dir -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_id_stage +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^TEST PASSED$'; then
    exit 0
fi
exit 1

/* verification/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int STIM_CYCLES = 60;   // rough length of the whole sequence
    localparam int WAIT_LIMIT  = 20;
    localparam int NUM_REACH   = 7;

    logic        clk;
    logic        resetn;
    logic        if_to_id_valid;
    word_t       if_inst;
    word_t       if_pc;
    logic        id_allowin;
    logic        id_to_exe_valid;
    exe_bundle_t id_bundle;
    logic        exe_allowin;
    logic        br_taken_exe;
    fwd_t        exe_fwd;
    fwd_t        mem_fwd;
    fwd_t        wb_fwd;
    logic        br_taken_id;
    word_t       br_target;

    logic [31:0] lfsr_state  = 32'hbe19;
    int          error_count = 0;
    int          reach [NUM_REACH] = '{default: 0};
    string       reach_name [NUM_REACH] = '{"reset", "register read and add decode",
        "forwarding from execute", "forwarding from memory", "load-use stall",
        "back-pressure", "jump redirect"};

    id_stage id_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .if_to_id_valid  (if_to_id_valid),
        .if_inst         (if_inst),
        .if_pc           (if_pc),
        .id_allowin      (id_allowin),
        .id_to_exe_valid (id_to_exe_valid),
        .id_bundle       (id_bundle),
        .exe_allowin     (exe_allowin),
        .br_taken_exe    (br_taken_exe),
        .exe_fwd         (exe_fwd),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .br_taken_id     (br_taken_id),
        .br_target       (br_target)
    );

    bind id_stage id_stage_assertions checks_i (
        .clk(clk), .resetn(resetn), .if_to_id_valid(if_to_id_valid), .if_inst(if_inst),
        .if_pc(if_pc), .id_allowin(id_allowin), .id_to_exe_valid(id_to_exe_valid),
        .id_bundle(id_bundle), .exe_allowin(exe_allowin), .br_taken_exe(br_taken_exe),
        .exe_fwd(exe_fwd), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
        .br_taken_id(br_taken_id), .br_target(br_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    function automatic word_t enc_add_w(input reg_idx_t rd, input reg_idx_t rj,
                                        input reg_idx_t rk);
        return {OP_ALU, F3_ADD_W, rk, rj, rd};
    endfunction

    function automatic word_t enc_addi_w(input reg_idx_t rd, input reg_idx_t rj,
                                         input logic [11:0] si12);
        return {OP_ALU, FI_ADDI_W, si12, rj, rd};
    endfunction

    function automatic word_t enc_jump(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};  // high offset bits go low
    endfunction

    function automatic word_t enc_branch(input logic [5:0] op, input reg_idx_t rj,
                                         input reg_idx_t rd, input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic fwd_t fwd_result(input reg_idx_t r, input word_t v, input logic load);
        fwd_t f;
        f.valid   = 1'b1;
        f.rf_we   = 1'b1;
        f.waddr   = r;
        f.wdata   = v;
        f.is_load = load;
        return f;
    endfunction

    task automatic send_inst(input word_t inst, input word_t pc);
        int n;
        if_to_id_valid <= 1'b1;
        if_inst        <= inst;
        if_pc          <= pc;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!id_allowin && n < WAIT_LIMIT);
        if (!id_allowin) begin
            error_count++;
            $display("decode stage never accepted instruction %h", inst);
        end
        if_to_id_valid <= 1'b0;
    endtask

    task automatic wait_transfer();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(id_to_exe_valid && exe_allowin) && n < WAIT_LIMIT);
        if (!(id_to_exe_valid && exe_allowin)) begin
            error_count++;
            $display("timed out waiting for an item to move to execute");
        end
    endtask

    task automatic write_reg(input reg_idx_t r, input word_t v);
        wb_fwd <= fwd_result(r, v, 1'b0);
        @(posedge clk);
        wb_fwd <= '0;
    endtask

    // a fetched item lands on the same edge as the jump and must be dropped
    task automatic jump_with_follower(input word_t inst, input word_t pc);
        send_inst(inst, pc);
        if_to_id_valid <= 1'b1;
        if_inst        <= enc_add_w(5'd2, 5'd3, 5'd4);
        if_pc          <= pc + 4;
        wait_transfer();
        if_to_id_valid <= 1'b0;
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!resetn)
            reach[0]++;
        if (id_to_exe_valid && !exe_fwd.valid && !mem_fwd.valid && !wb_fwd.valid)
            reach[1]++;
        if (id_to_exe_valid && exe_fwd.valid && mem_fwd.valid && wb_fwd.valid)
            reach[2]++;
        if (id_to_exe_valid && !exe_fwd.valid && mem_fwd.valid)
            reach[3]++;
        if (exe_fwd.valid && exe_fwd.is_load && !id_allowin)
            reach[4]++;
        if (id_to_exe_valid && !exe_allowin)
            reach[5]++;
        if (br_taken_id)
            reach[6]++;
    end

    initial begin
        reg_idx_t    ra, rb, rc;
        logic [31:0] bits;
        word_t       pc;
        int          i;
        resetn         <= 1'b0;
        if_to_id_valid <= 1'b0;
        if_inst        <= '0;
        if_pc          <= '0;
        exe_allowin    <= 1'b1;
        br_taken_exe   <= 1'b0;
        exe_fwd        <= '0;
        mem_fwd        <= '0;
        wb_fwd         <= '0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) @(posedge clk);

        bits = take_bits(3);
        ra   = 5'd1 + {2'b00, bits[2:0]};  // sources kept apart
        rb   = ra + 5'd8;
        rc   = ra + 5'd16;
        bits = take_bits(30);
        pc   = {bits[29:0], 2'b00};
        write_reg(ra, take_bits(32));
        write_reg(rb, take_bits(32));

        send_inst(enc_add_w(rc, ra, rb), pc);
        wait_transfer();
        bits = take_bits(12);
        send_inst(enc_addi_w(rc, ra, bits[11:0]), pc + 4);
        wait_transfer();

        // held by execute, then every younger stage writes rj
        exe_allowin <= 1'b0;
        send_inst(enc_add_w(rc, ra, rb), pc + 8);
        repeat (3) @(posedge clk);
        exe_fwd <= fwd_result(ra, take_bits(32), 1'b0);
        mem_fwd <= fwd_result(ra, take_bits(32), 1'b0);
        wb_fwd  <= fwd_result(ra, take_bits(32), 1'b0);
        @(posedge clk);
        exe_fwd <= '0;
        @(posedge clk);
        mem_fwd     <= '0;
        wb_fwd      <= '0;
        exe_allowin <= 1'b1;
        wait_transfer();

        exe_fwd <= fwd_result(rb, take_bits(32), 1'b1);  // load on rk
        send_inst(enc_add_w(rc, ra, rb), pc + 12);
        repeat (3) @(posedge clk);
        exe_fwd <= '0;
        wait_transfer();

        bits = take_bits(26);
        jump_with_follower(enc_jump(OP_B, bits[25:0]), pc + 16);
        bits = take_bits(26);
        jump_with_follower(enc_jump(OP_BL, bits[25:0]), pc + 24);
        bits = take_bits(16);
        send_inst(enc_branch(OP_BEQ, ra, rb, bits[15:0]), pc + 32);
        wait_transfer();
        repeat (3) @(posedge clk);

        for (i = 0; i < NUM_REACH; i++) begin
            if (reach[i] == 0) begin
                error_count++;
                $display("behavior '%s' was never reached", reach_name[i]);
            end
        end
        $display("errors: %0d assertion failures, %0d testbench errors",
                 id_stage_i.checks_i.fail_count, error_count);
        if (error_count == 0 && id_stage_i.checks_i.fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(20 * STIM_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the sequence did not finish",
                 20 * STIM_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verification/id_stage_assertions.sv */
`timescale 1ns/1ps

module id_stage_assertions (
    input logic                  clk,
    input logic                  resetn,
    input logic                  if_to_id_valid,
    input isa_pkg::word_t        if_inst,
    input isa_pkg::word_t        if_pc,
    input logic                  id_allowin,
    input logic                  id_to_exe_valid,
    input pipe_pkg::exe_bundle_t id_bundle,
    input logic                  exe_allowin,
    input logic                  br_taken_exe,
    input pipe_pkg::fwd_t        exe_fwd,
    input pipe_pkg::fwd_t        mem_fwd,
    input pipe_pkg::fwd_t        wb_fwd,
    input logic                  br_taken_id,
    input isa_pkg::word_t        br_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    int       fail_count = 0;
    word_t    held_inst;                // last instruction accepted from fetch
    word_t    held_pc;
    word_t    shadow_rf [NUM_REGS];     // what writeback has written so far
    reg_idx_t held_rj;
    reg_idx_t held_rk;
    logic     held_add, held_addi, held_b, held_bl, held_cond;
    logic     exe_hit, mem_hit, wb_hit;
    logic     load_use;
    word_t    rf_value;
    word_t    exp_si12;
    word_t    exp_jump_target;
    word_t    exp_cond_target;

    function automatic logic writes_reg(input fwd_t f, input reg_idx_t r);
        return f.valid && f.rf_we && r != 5'd0 && f.waddr == r;
    endfunction

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            held_inst <= if_inst;
            held_pc   <= if_pc;
        end
        if (wb_fwd.valid && wb_fwd.rf_we && wb_fwd.waddr != 5'd0)
            shadow_rf[wb_fwd.waddr] <= wb_fwd.wdata;
    end

    assign held_rj   = held_inst[9:5];
    assign held_rk   = held_inst[14:10];
    assign held_add  = held_inst[31:26] == OP_ALU && held_inst[25:15] == F3_ADD_W;
    assign held_addi = held_inst[31:26] == OP_ALU && held_inst[25:22] == FI_ADDI_W;
    assign held_b    = held_inst[31:26] == OP_B;
    assign held_bl   = held_inst[31:26] == OP_BL;
    assign held_cond = held_inst[31:26] >= OP_BEQ && held_inst[31:26] <= OP_BGEU;

    assign exe_hit  = writes_reg(exe_fwd, held_rj);
    assign mem_hit  = writes_reg(mem_fwd, held_rj);
    assign wb_hit   = writes_reg(wb_fwd, held_rj);
    assign load_use = held_add && exe_fwd.is_load
                    && (writes_reg(exe_fwd, held_rj) || writes_reg(exe_fwd, held_rk));

    assign rf_value        = (held_rj == 5'd0) ? '0 : shadow_rf[held_rj];
    assign exp_si12        = {{20{held_inst[21]}}, held_inst[21:10]};
    // si26 is split, offs[25:16] in the low ten bits
    assign exp_jump_target = held_pc + {{4{held_inst[9]}}, held_inst[9:0], held_inst[25:10], 2'b00};
    assign exp_cond_target = held_pc + {{14{held_inst[25]}}, held_inst[25:10], 2'b00};

    a_reset_hold: assert property (@(posedge clk)
        !resetn |=> !id_to_exe_valid && !br_taken_id && id_allowin)
    else begin
        fail_count++;
        $error("[FAIL] during reset id_to_exe_valid %h br_taken_id %h id_allowin %h",
               id_to_exe_valid, br_taken_id, id_allowin);
    end

    a_reset_after: assert property (@(posedge clk)
        $rose(resetn) |=> !id_to_exe_valid && !br_taken_id && id_allowin)
    else begin
        fail_count++;
        $error("[FAIL] after reset id_to_exe_valid %h br_taken_id %h id_allowin %h",
               id_to_exe_valid, br_taken_id, id_allowin);
    end

    a_rf_read: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && held_add && !exe_hit && !mem_hit && !wb_hit
        |-> id_bundle.alu_src1 == rf_value)
    else begin
        fail_count++;
        $error("[FAIL] alu_src1 %h expected %h", id_bundle.alu_src1, rf_value);
    end

    a_add_op: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && held_add |-> $onehot(id_bundle.alu_op) && id_bundle.alu_op[ALU_ADD])
    else begin
        fail_count++;
        $error("[FAIL] alu_op %h expected only bit %0d", id_bundle.alu_op, ALU_ADD);
    end

    a_addi_imm: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && held_addi |-> id_bundle.alu_src2 == exp_si12)
    else begin
        fail_count++;
        $error("[FAIL] alu_src2 %h expected %h", id_bundle.alu_src2, exp_si12);
    end

    a_fwd_exe: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && held_add && exe_hit |-> id_bundle.alu_src1 == exe_fwd.wdata)
    else begin
        fail_count++;
        $error("[FAIL] alu_src1 %h expected %h", id_bundle.alu_src1, exe_fwd.wdata);
    end

    a_fwd_mem: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && held_add && !exe_hit && mem_hit
        |-> id_bundle.alu_src1 == mem_fwd.wdata)
    else begin
        fail_count++;
        $error("[FAIL] alu_src1 %h expected %h", id_bundle.alu_src1, mem_fwd.wdata);
    end

    a_load_use: assert property (@(posedge clk) disable iff (!resetn)
        load_use |-> !id_to_exe_valid)
    else begin
        fail_count++;
        $error("[FAIL] id_to_exe_valid %h expected 0 under load-use", id_to_exe_valid);
    end

    a_hold_allowin: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && !exe_allowin |-> !id_allowin)
    else begin
        fail_count++;
        $error("[FAIL] id_allowin %h expected 0 under back-pressure", id_allowin);
    end

    a_hold_bundle: assert property (@(posedge clk) disable iff (!resetn)
        $past(id_to_exe_valid && !exe_allowin && !br_taken_exe)
        && $stable(exe_fwd) && $stable(mem_fwd) && $stable(wb_fwd)
        |-> $stable(id_bundle))
    else begin
        fail_count++;
        $error("[FAIL] id_bundle %h changed from %h", id_bundle, $past(id_bundle));
    end

    a_jump_target: assert property (@(posedge clk) disable iff (!resetn)
        br_taken_id && (held_b || held_bl) |-> br_target == exp_jump_target)
    else begin
        fail_count++;
        $error("[FAIL] br_target %h expected %h", br_target, exp_jump_target);
    end

    a_bl_link: assert property (@(posedge clk) disable iff (!resetn)
        br_taken_id && held_bl |-> id_bundle.dest == LINK_REG && id_bundle.alu_src2 == 32'd4)
    else begin
        fail_count++;
        $error("[FAIL] dest %h alu_src2 %h expected %h and 00000004",
               id_bundle.dest, id_bundle.alu_src2, LINK_REG);
    end

    a_jump_flush: assert property (@(posedge clk) disable iff (!resetn)
        br_taken_id |=> !id_to_exe_valid)
    else begin
        fail_count++;
        $error("[FAIL] id_to_exe_valid %h expected 0 after a jump", id_to_exe_valid);
    end

    a_cond_target: assert property (@(posedge clk) disable iff (!resetn)
        id_to_exe_valid && held_cond |-> br_target == exp_cond_target)
    else begin
        fail_count++;
        $error("[FAIL] br_target %h expected %h", br_target, exp_cond_target);
    end

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  if_to_id_valid,
    input  isa_pkg::word_t        if_inst,
    input  isa_pkg::word_t        if_pc,
    output logic                  id_allowin,
    output logic                  id_to_exe_valid,
    output pipe_pkg::exe_bundle_t id_bundle,
    input  logic                  exe_allowin,
    input  logic                  br_taken_exe,
    input  pipe_pkg::fwd_t        exe_fwd,
    input  pipe_pkg::fwd_t        mem_fwd,
    input  pipe_pkg::fwd_t        wb_fwd,
    output logic                  br_taken_id,
    output isa_pkg::word_t        br_target
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic      id_valid;
    word_t     id_pc;
    word_t     id_inst;
    dec_ctrl_t ctrl;
    word_t     rj_value;
    word_t     rkd_value;
    logic      load_use;
    logic      ready_go;

    inst_decoder u_decoder (
        .inst (id_inst),
        .ctrl (ctrl)
    );

    operand_bypass u_bypass (
        .clk       (clk),
        .rj        (ctrl.rj),
        .r2_idx    (ctrl.r2),
        .need_r1   (ctrl.need_r1),
        .need_r2   (ctrl.need_r2),
        .exe_fwd   (exe_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (load_use)
    );

    assign ready_go        = ~load_use;
    assign id_to_exe_valid = id_valid & ready_go;
    assign id_allowin      = ~id_valid | (ready_go & exe_allowin);

    // jump leaves for execute this cycle
    assign br_taken_id = id_to_exe_valid & exe_allowin & ctrl.jump;
    assign br_target   = ctrl.is_jirl ? rj_value + ctrl.br_offs : id_pc + ctrl.br_offs;

    always_ff @(posedge clk) begin
        if (!resetn)
            id_valid <= 1'b0;
        else if (br_taken_exe || br_taken_id)
            id_valid <= 1'b0;  // drops anything fetched down the wrong path
        else if (id_allowin)
            id_valid <= if_to_id_valid;
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_pc   <= if_pc;
            id_inst <= if_inst;
        end
    end

    always_comb begin
        id_bundle.pc           = id_pc;
        id_bundle.alu_op       = ctrl.alu_op;
        id_bundle.alu_src1     = ctrl.src1_is_pc ? id_pc : rj_value;
        if (ctrl.src2_is_imm || ctrl.src2_is_4)
            id_bundle.alu_src2 = ctrl.imm;  // 4 gives link address pc + 4
        else
            id_bundle.alu_src2 = rkd_value;
        id_bundle.rkd_value    = rkd_value;
        id_bundle.mem_ctrl     = ctrl.mem_ctrl;
        id_bundle.res_from_mem = ctrl.res_from_mem;
        id_bundle.rf_we        = ctrl.rf_we;
        id_bundle.dest         = ctrl.dest;
        id_bundle.br_cond      = ctrl.br_cond;
    end

endmodule

/* verilog/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  logic              clk,
    input  isa_pkg::reg_idx_t rj,
    input  isa_pkg::reg_idx_t r2_idx,
    input  logic              need_r1,
    input  logic              need_r2,
    input  pipe_pkg::fwd_t    exe_fwd,
    input  pipe_pkg::fwd_t    mem_fwd,
    input  pipe_pkg::fwd_t    wb_fwd,
    output isa_pkg::word_t    rj_value,
    output isa_pkg::word_t    rkd_value,
    output logic              stall
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t rf_rdata1;
    word_t rf_rdata2;

    // younger stage is about to write this source
    function automatic logic hits(input fwd_t fwd, input reg_idx_t idx);
        return fwd.valid && fwd.rf_we && (idx != '0) && (fwd.waddr == idx);
    endfunction

    // youngest match wins
    function automatic word_t pick(input logic need, input reg_idx_t idx, input word_t rf_data,
                                   input fwd_t e, input fwd_t m, input fwd_t w);
        if (need && hits(e, idx))
            return e.wdata;
        else if (need && hits(m, idx))
            return m.wdata;
        else if (need && hits(w, idx))
            return w.wdata;
        return rf_data;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rf_rdata1),
        .raddr2 (r2_idx),
        .rdata2 (rf_rdata2),
        .we     (wb_fwd.valid & wb_fwd.rf_we),
        .waddr  (wb_fwd.waddr),
        .wdata  (wb_fwd.wdata)
    );

    assign rj_value  = pick(need_r1, rj, rf_rdata1, exe_fwd, mem_fwd, wb_fwd);
    assign rkd_value = pick(need_r2, r2_idx, rf_rdata2, exe_fwd, mem_fwd, wb_fwd);

    // load data not ready until memory stage
    assign stall = exe_fwd.is_load
                 & ((need_r1 & hits(exe_fwd, rj)) | (need_r2 & hits(exe_fwd, r2_idx)));

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  isa_pkg::reg_idx_t raddr1,
    output isa_pkg::word_t    rdata1,
    input  isa_pkg::reg_idx_t raddr2,
    output isa_pkg::word_t    rdata2,
    input  logic              we,
    input  isa_pkg::reg_idx_t waddr,
    input  isa_pkg::word_t    wdata
);
    import isa_pkg::*;

    word_t rf [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::word_t      inst,
    output pipe_pkg::dec_ctrl_t ctrl
);
    import isa_pkg::*;

    logic [5:0]  op;
    logic [10:0] op_3r;
    logic [3:0]  op_ri;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic        is_alu;
    logic        is_mem;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic inst_jirl, inst_b, inst_bl;
    logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;

    logic need_ui5;
    logic need_ui12;
    logic need_si12;
    logic need_si20;
    logic is_load;
    logic is_store;
    logic is_cond_br;

    assign op    = inst[OP_LSB +: 6];
    assign op_3r = inst[25:15];
    assign op_ri = inst[25:22];
    assign rd    = inst[RD_LSB +: 5];
    assign rj    = inst[RJ_LSB +: 5];
    assign rk    = inst[RK_LSB +: 5];
    assign i12   = inst[I12_LSB +: 12];
    assign i16   = inst[I16_LSB +: 16];
    assign i20   = inst[I20_LSB +: 20];
    assign i26   = {inst[9:0], i16};  // offs[25:16] sits in the low bits

    assign is_alu = (op == OP_ALU);
    assign is_mem = (op == OP_MEM);

    assign inst_add_w  = is_alu & (op_3r == F3_ADD_W);
    assign inst_sub_w  = is_alu & (op_3r == F3_SUB_W);
    assign inst_slt    = is_alu & (op_3r == F3_SLT);
    assign inst_sltu   = is_alu & (op_3r == F3_SLTU);
    assign inst_nor    = is_alu & (op_3r == F3_NOR);
    assign inst_and    = is_alu & (op_3r == F3_AND);
    assign inst_or     = is_alu & (op_3r == F3_OR);
    assign inst_xor    = is_alu & (op_3r == F3_XOR);
    assign inst_sll_w  = is_alu & (op_3r == F3_SLL_W);
    assign inst_srl_w  = is_alu & (op_3r == F3_SRL_W);
    assign inst_sra_w  = is_alu & (op_3r == F3_SRA_W);
    assign inst_slli_w = is_alu & (op_3r == F3_SLLI_W);
    assign inst_srli_w = is_alu & (op_3r == F3_SRLI_W);
    assign inst_srai_w = is_alu & (op_3r == F3_SRAI_W);

    assign inst_slti   = is_alu & (op_ri == FI_SLTI);
    assign inst_sltui  = is_alu & (op_ri == FI_SLTUI);
    assign inst_addi_w = is_alu & (op_ri == FI_ADDI_W);
    assign inst_andi   = is_alu & (op_ri == FI_ANDI);
    assign inst_ori    = is_alu & (op_ri == FI_ORI);
    assign inst_xori   = is_alu & (op_ri == FI_XORI);

    assign inst_lu12i_w   = (op == OP_LU12I) & ~inst[25];
    assign inst_pcaddu12i = (op == OP_PCADDU12I) & ~inst[25];

    assign inst_ld_b  = is_mem & (op_ri == FM_LD_B);
    assign inst_ld_h  = is_mem & (op_ri == FM_LD_H);
    assign inst_ld_w  = is_mem & (op_ri == FM_LD_W);
    assign inst_ld_bu = is_mem & (op_ri == FM_LD_BU);
    assign inst_ld_hu = is_mem & (op_ri == FM_LD_HU);
    assign inst_st_b  = is_mem & (op_ri == FM_ST_B);
    assign inst_st_h  = is_mem & (op_ri == FM_ST_H);
    assign inst_st_w  = is_mem & (op_ri == FM_ST_W);

    assign inst_jirl = (op == OP_JIRL);
    assign inst_b    = (op == OP_B);
    assign inst_bl   = (op == OP_BL);
    assign inst_beq  = (op == OP_BEQ);
    assign inst_bne  = (op == OP_BNE);
    assign inst_blt  = (op == OP_BLT);
    assign inst_bge  = (op == OP_BGE);
    assign inst_bltu = (op == OP_BLTU);
    assign inst_bgeu = (op == OP_BGEU);

    assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    assign is_store   = inst_st_b | inst_st_h | inst_st_w;
    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | is_load | is_store;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;

    always_comb begin
        ctrl.alu_op           = '0;
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | is_load | is_store
                              | inst_jirl | inst_bl | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti | inst_blt | inst_bge;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;

        ctrl.src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu12i;  // link or pc-relative
        ctrl.src2_is_imm = need_ui5 | need_ui12 | need_si12 | need_si20;
        ctrl.src2_is_4   = inst_jirl | inst_bl;

        if (need_si20)
            ctrl.imm = {i20, 12'b0};
        else if (need_ui12)
            ctrl.imm = {20'b0, i12};
        else if (need_ui5)
            ctrl.imm = {27'b0, rk};  // shift amount
        else if (ctrl.src2_is_4)
            ctrl.imm = 32'd4;
        else
            ctrl.imm = {{20{i12[11]}}, i12};

        ctrl.rj      = rj;
        ctrl.r2      = (is_store | is_cond_br) ? rd : rk;
        ctrl.need_r1 = ~(inst_lu12i_w | inst_pcaddu12i | inst_b | inst_bl);
        ctrl.need_r2 = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                     | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w
                     | is_store | is_cond_br;

        ctrl.rf_we = ctrl.alu_op[ALU_SUB] | (|ctrl.alu_op[ALU_LUI:ALU_AND]) | inst_add_w
                   | inst_addi_w | inst_slt | inst_slti | inst_sltu | inst_sltui
                   | inst_pcaddu12i | is_load | inst_jirl | inst_bl;
        ctrl.dest  = inst_bl ? LINK_REG : rd;

        ctrl.mem_ctrl.mem_we = is_store;
        ctrl.mem_ctrl.ld_b   = inst_ld_b | inst_ld_bu;
        ctrl.mem_ctrl.ld_h   = inst_ld_h | inst_ld_hu;
        ctrl.mem_ctrl.ld_w   = inst_ld_w;
        ctrl.mem_ctrl.ld_se  = inst_ld_b | inst_ld_h;
        ctrl.mem_ctrl.st_b   = inst_st_b;
        ctrl.mem_ctrl.st_h   = inst_st_h;
        ctrl.mem_ctrl.st_w   = inst_st_w;
        ctrl.res_from_mem    = is_load;

        ctrl.jump         = inst_b | inst_bl | inst_jirl;
        ctrl.is_jirl      = inst_jirl;
        ctrl.br_cond.beq  = inst_beq;
        ctrl.br_cond.bne  = inst_bne;
        ctrl.br_cond.blt  = inst_blt;
        ctrl.br_cond.bltu = inst_bltu;
        ctrl.br_cond.bge  = inst_bge;
        ctrl.br_cond.bgeu = inst_bgeu;

        // word offsets, si26 only for b and bl
        ctrl.br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                          : {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

/* verilog/pipe_pkg.sv */
package pipe_pkg;
    import isa_pkg::*;

    typedef struct packed {
        logic mem_we;
        logic ld_b;
        logic ld_h;
        logic ld_w;
        logic ld_se;    // sign extend the loaded byte or half
        logic st_b;
        logic st_h;
        logic st_w;
    } mem_ctrl_t;

    // conditions resolved in execute
    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bltu;
        logic bge;
        logic bgeu;
    } br_cond_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_4;
        word_t     imm;
        reg_idx_t  rj;
        reg_idx_t  r2;          // rk, or rd for stores and branches
        logic      need_r1;
        logic      need_r2;
        logic      rf_we;
        reg_idx_t  dest;
        mem_ctrl_t mem_ctrl;
        logic      res_from_mem;
        logic      jump;        // b, bl, jirl
        logic      is_jirl;
        br_cond_t  br_cond;
        word_t     br_offs;
    } dec_ctrl_t;

    typedef struct packed {
        word_t     pc;
        alu_op_t   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        word_t     rkd_value;   // store data, branch compare operand
        mem_ctrl_t mem_ctrl;
        logic      res_from_mem;
        logic      rf_we;
        reg_idx_t  dest;
        br_cond_t  br_cond;
    } exe_bundle_t;

    // result reported back by a younger stage
    typedef struct packed {
        logic     valid;
        logic     rf_we;
        reg_idx_t waddr;
        word_t    wdata;
        logic     is_load;  // only from execute
    } fwd_t;

endpackage

/* verilog/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] word_t;     // data, address or instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register number

    localparam int       NUM_REGS = 32;
    localparam reg_idx_t LINK_REG = 5'd1;  // return address of bl

    // instruction field positions
    localparam int OP_LSB  = 26;
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int I12_LSB = 10;
    localparam int I16_LSB = 10;
    localparam int I20_LSB = 5;

    // one-hot alu operation, bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;
    localparam int ALU_OP_W = 12;

    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // major opcodes, bits 31:26
    localparam logic [5:0] OP_ALU       = 6'h00;
    localparam logic [5:0] OP_LU12I     = 6'h05;
    localparam logic [5:0] OP_PCADDU12I = 6'h07;
    localparam logic [5:0] OP_MEM       = 6'h0a;
    localparam logic [5:0] OP_JIRL      = 6'h13;
    localparam logic [5:0] OP_B         = 6'h14;
    localparam logic [5:0] OP_BL        = 6'h15;
    localparam logic [5:0] OP_BEQ       = 6'h16;
    localparam logic [5:0] OP_BNE       = 6'h17;
    localparam logic [5:0] OP_BLT       = 6'h18;
    localparam logic [5:0] OP_BGE       = 6'h19;
    localparam logic [5:0] OP_BLTU      = 6'h1a;
    localparam logic [5:0] OP_BGEU      = 6'h1b;

    // register forms and shift-immediates, bits 25:15
    localparam logic [10:0] F3_ADD_W  = 11'h020;
    localparam logic [10:0] F3_SUB_W  = 11'h022;
    localparam logic [10:0] F3_SLT    = 11'h024;
    localparam logic [10:0] F3_SLTU   = 11'h025;
    localparam logic [10:0] F3_NOR    = 11'h028;
    localparam logic [10:0] F3_AND    = 11'h029;
    localparam logic [10:0] F3_OR     = 11'h02a;
    localparam logic [10:0] F3_XOR    = 11'h02b;
    localparam logic [10:0] F3_SLL_W  = 11'h02e;
    localparam logic [10:0] F3_SRL_W  = 11'h02f;
    localparam logic [10:0] F3_SRA_W  = 11'h030;
    localparam logic [10:0] F3_SLLI_W = 11'h081;
    localparam logic [10:0] F3_SRLI_W = 11'h089;
    localparam logic [10:0] F3_SRAI_W = 11'h091;

    // 12-bit immediate forms, bits 25:22
    localparam logic [3:0] FI_SLTI   = 4'h8;
    localparam logic [3:0] FI_SLTUI  = 4'h9;
    localparam logic [3:0] FI_ADDI_W = 4'ha;
    localparam logic [3:0] FI_ANDI   = 4'hd;
    localparam logic [3:0] FI_ORI    = 4'he;
    localparam logic [3:0] FI_XORI   = 4'hf;

    // memory forms under OP_MEM, bits 25:22
    localparam logic [3:0] FM_LD_B  = 4'h0;
    localparam logic [3:0] FM_LD_H  = 4'h1;
    localparam logic [3:0] FM_LD_W  = 4'h2;
    localparam logic [3:0] FM_ST_B  = 4'h4;
    localparam logic [3:0] FM_ST_H  = 4'h5;
    localparam logic [3:0] FM_ST_W  = 4'h6;
    localparam logic [3:0] FM_LD_BU = 4'h8;
    localparam logic [3:0] FM_LD_HU = 4'h9;

endpackage
